// ==== verilog.f ====
clk_div_pkg.sv
rcomp_pkg.sv
aib_clk_div_rcomp.sv
rcomp_in_sync.sv
rcomp_calibration_fsm.sv
rcomp_cal_top.sv
rcomp_cal_chk.sv
tb_rcomp_cal.sv

// ==== Makefile ====
# Verilator lint and simulation of the rcomp calibration block

TOP := tb_rcomp_cal

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== tb_rcomp_cal.sv ====
// Testbench for the rcomp calibration top level
// Comparator model, one stimulus sequence per test and a result line per test

`timescale 1ns/1ns

module tb_rcomp_cal;

  localparam int SIG_DONE = 0;
  localparam int SIG_EN   = 1;
  localparam int SIG_ACK  = 2;

  logic sys_div_clk, rst_n, scan_mode, clk_div_ld, pad_data, start_cal;
  logic gen1mode_en, rcomp_cal_ovrd_sel, rcomp_cal_done_ovrd;
  logic rcomp_cal_en, rcomp_cal_done, clk_div_ld_ack;
  clk_div_pkg::div_sel_t  clk_div_sel;
  rcomp_pkg::rcomp_code_t rcomp_cal_code_ovrd, rcomp_cal_code;

  int err_cnt  = 0;
  int test_err = 0;  // err_cnt when the current test began
  int pass_cnt = 0;
  int fail_cnt = 0;
  int rclk_cnt = 0;  // Rising rcomp_clk edges so far

  rcomp_cal_top u_rcomp_cal_top (
    .sys_div_clk         (sys_div_clk),
    .rst_n               (rst_n),
    .scan_mode           (scan_mode),
    .clk_div_ld          (clk_div_ld),
    .clk_div_sel         (clk_div_sel),
    .pad_data            (pad_data),
    .start_cal           (start_cal),
    .gen1mode_en         (gen1mode_en),
    .rcomp_cal_ovrd_sel  (rcomp_cal_ovrd_sel),
    .rcomp_cal_done_ovrd (rcomp_cal_done_ovrd),
    .rcomp_cal_code_ovrd (rcomp_cal_code_ovrd),
    .rcomp_cal_en        (rcomp_cal_en),
    .rcomp_cal_done      (rcomp_cal_done),
    .rcomp_cal_code      (rcomp_cal_code),
    .clk_div_ld_ack      (clk_div_ld_ack)
  );

  initial begin
    sys_div_clk = 1'b0;
    forever #2 sys_div_clk = ~sys_div_clk;
  end

  always @(posedge u_rcomp_cal_top.rcomp_clk) begin
    rclk_cnt <= rclk_cnt + 1;  // Comparator model time base
  end

  // ==================
  // Helpers
  // ==================
  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      $display("** Error [%0t] %s", $time, msg);
      err_cnt++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    err_cnt++;
    $display("Timeout waiting for %s at %0t, the DUT stopped responding", what, $time);
    $display("tests failed");
    $finish;
  endtask

  // Ends 1 ns after the last rising edge, where inputs are driven
  task automatic step_sys(input int n);
    repeat (n) begin
      @(posedge sys_div_clk);
      #1;
    end
  endtask

  task automatic wait_rclk(input int n);
    int target;
    int cyc;
    target = rclk_cnt + n;
    cyc = 0;
    while (rclk_cnt < target && cyc < 40 * n + 40) begin
      step_sys(1);
      cyc++;
    end
    if (rclk_cnt < target) abort_on_timeout("rcomp_clk edges");
  endtask

  function automatic logic probe(input int which);
    case (which)
      SIG_DONE: return rcomp_cal_done;
      SIG_EN:   return rcomp_cal_en;
      default:  return clk_div_ld_ack;
    endcase
  endfunction

  task automatic wait_level(input int which, input logic level, input string name,
                            output int cyc);
    cyc = 0;
    while (probe(which) !== level && cyc < 2000) begin
      step_sys(1);
      cyc++;
    end
    if (probe(which) !== level) abort_on_timeout(name);
  endtask

  // Comparator trips trip edges after start and never when trip is negative
  task automatic run_cal(input int trip, output int elapsed);
    int base;
    int cyc;
    base = rclk_cnt;
    start_cal = 1'b1;
    if (trip >= 0) begin
      wait_rclk(trip);
      pad_data = ~pad_data;
    end
    wait_level(SIG_DONE, 1'b1, "rcomp_cal_done", cyc);
    elapsed = rclk_cnt - base;
  endtask

  task automatic stop_cal;
    int cyc;
    start_cal = 1'b0;
    pad_data  = 1'b0;
    wait_level(SIG_EN, 1'b1, "rcomp_cal_en after restart", cyc);
  endtask

  // Edge is captured with the count one past the reported code
  task automatic check_code(input int trip, input bit gen1);
    rcomp_pkg::rcomp_code_t cnt;
    int got;
    cnt = gen1 ? rcomp_cal_code : ~rcomp_cal_code;
    got = int'(cnt);
    check(got >= trip - 2 && got <= trip,
          $sformatf("code count %0d, expected %0d within one", got, trip - 1));
  endtask

  task automatic measure_rclk(output int cyc);
    int base;
    wait_rclk(1);
    base = rclk_cnt;
    cyc = 0;
    while (rclk_cnt == base && cyc < 100) begin
      step_sys(1);
      cyc++;
    end
  endtask

  task automatic load_ratio(input clk_div_pkg::div_sel_t sel);
    int cyc;
    clk_div_sel = sel;
    clk_div_ld  = 1'b1;
    wait_level(SIG_ACK, 1'b1, "clk_div_ld_ack high", cyc);
    check(cyc == 2, $sformatf("ack rose after %0d cycles, expected 2", cyc));
    clk_div_ld = 1'b0;
    wait_level(SIG_ACK, 1'b0, "clk_div_ld_ack low", cyc);
    check(cyc == 2, $sformatf("ack fell after %0d cycles, expected 2", cyc));
    step_sys(40);  // New ratio applies at the next counter wrap
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_err) begin
      pass_cnt++;
      $display("[%0t] PASS %s", $time, name);
    end else begin
      fail_cnt++;
      $display("[%0t] FAIL %s, %0d errors", $time, name, err_cnt - test_err);
    end
    test_err = err_cnt;
  endtask

  // ==================
  // Test sequence
  // ==================
  initial begin
    int trip, elapsed, cyc, base, chk_fails;
    rcomp_pkg::rcomp_code_t ovrd_val;
    void'($urandom(32'hbded));
    rst_n               = 1'b0;
    scan_mode           = 1'b0;
    clk_div_ld          = 1'b0;
    clk_div_sel         = clk_div_pkg::DIV_SEL_RESET;
    pad_data            = 1'b0;
    start_cal           = 1'b0;
    gen1mode_en         = 1'b1;
    rcomp_cal_ovrd_sel  = 1'b0;
    rcomp_cal_done_ovrd = 1'b0;
    rcomp_cal_code_ovrd = '0;
    step_sys(3);
    rst_n = 1'b1;
    check(rcomp_cal_en === 1'b0 && rcomp_cal_done === 1'b0 && clk_div_ld_ack === 1'b0,
          "enable, done or acknowledge not low after reset");
    trip = 8 + int'($urandom % 33);
    run_cal(trip, elapsed);
    check_code(trip, 1'b1);
    finish_test("reset and gen1 calibration");

    stop_cal();
    gen1mode_en = 1'b0;
    trip = 8 + int'($urandom % 33);
    run_cal(trip, elapsed);
    check_code(trip, 1'b0);
    stop_cal();
    gen1mode_en = 1'b1;
    run_cal(-1, elapsed);  // No comparator flip so the count runs to full scale
    check_code(trip, 1'b1);  // Still the count captured in the Gen2 run
    check(elapsed >= rcomp_pkg::GEN1_MAX + 4 && elapsed <= rcomp_pkg::GEN1_MAX + 6,
          $sformatf("full-scale run took %0d edges", elapsed));
    finish_test("gen2 inversion and full scale");

    stop_cal();
    load_ratio(clk_div_pkg::DIV_SEL_8);
    measure_rclk(cyc);
    check(cyc == 8, $sformatf("rcomp_clk period %0d cycles, expected 8", cyc));
    load_ratio(6'b010001);
    measure_rclk(cyc);
    check(cyc == 8, $sformatf("period %0d after invalid load, expected 8", cyc));
    finish_test("ratio change");

    ovrd_val = rcomp_pkg::rcomp_code_t'($urandom);
    base = rclk_cnt;
    start_cal = 1'b1;
    wait_rclk(6);  // Counting by now
    rcomp_cal_ovrd_sel  = 1'b1;
    rcomp_cal_done_ovrd = 1'b1;
    rcomp_cal_code_ovrd = ovrd_val;
    #1;
    check(rcomp_cal_code === ovrd_val && rcomp_cal_done === 1'b1,
          "override not applied while counting");
    step_sys(1);
    rcomp_cal_ovrd_sel = 1'b0;
    #1;
    check(rcomp_cal_done === 1'b0, "done high while counting without override");
    wait_rclk(base + 12 - rclk_cnt);
    pad_data = ~pad_data;
    wait_level(SIG_DONE, 1'b1, "rcomp_cal_done", cyc);
    check_code(12, 1'b1);
    rcomp_cal_ovrd_sel  = 1'b1;
    rcomp_cal_done_ovrd = 1'b0;
    #1;
    check(rcomp_cal_code === ovrd_val && rcomp_cal_done === 1'b0,
          "override not applied in STOP");
    step_sys(1);
    rcomp_cal_ovrd_sel = 1'b0;
    finish_test("overrides");

    stop_cal();
    scan_mode          = 1'b1;
    rcomp_cal_ovrd_sel = 1'b1;
    #1;
    check(rcomp_cal_code === '0, "code not zero in scan mode");
    repeat (4) begin
      step_sys(1);
      check(u_rcomp_cal_top.rcomp_clk === sys_div_clk, "rcomp_clk high phase differs in scan");
      @(negedge sys_div_clk);
      #1;
      check(u_rcomp_cal_top.rcomp_clk === sys_div_clk, "rcomp_clk low phase differs in scan");
    end
    step_sys(1);
    scan_mode          = 1'b0;
    rcomp_cal_ovrd_sel = 1'b0;
    finish_test("scan mode");

    trip = 8 + int'($urandom % 33);
    run_cal(trip, elapsed);
    check_code(trip, 1'b1);
    stop_cal();
    check(rcomp_cal_done === 1'b0, "done still high after restart");
    trip = 8 + int'($urandom % 33);
    run_cal(trip, elapsed);
    check_code(trip, 1'b1);
    finish_test("recalibration");

    chk_fails = int'(u_rcomp_cal_top.u_rcomp_cal_chk.assert_fail_cnt);
    $display("Summary: %0d passed, %0d failed, %0d assertion failures",
             pass_cnt, fail_cnt, chk_fails);
    if (fail_cnt == 0 && chk_fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== rcomp_cal_chk.sv ====
// Bound checks on the rcomp calibration top level
// Enable and done exclusion, scan code, load acknowledge, done clear on restart

`timescale 1ns/1ns

module rcomp_cal_chk (
  input logic                    sys_div_clk,
  input logic                    rcomp_clk,
  input logic                    rst_n,
  input logic                    scan_mode,
  input logic                    clk_div_ld,
  input logic                    clk_div_ld_ack,
  input logic                    rcomp_cal_ovrd_sel,
  input logic                    rcomp_cal_en,
  input logic                    rcomp_cal_done,
  input rcomp_pkg::rcomp_code_t  rcomp_cal_code,
  input rcomp_pkg::rcomp_state_e fsm_state
);

  int unsigned assert_fail_cnt = 0;  // Failed assertions so far

  // ==================
  // Port level rules
  // ==================
  en_off_when_done: assert property (@(posedge sys_div_clk) disable iff (!rst_n)
    (rcomp_cal_done && !rcomp_cal_ovrd_sel) |-> !rcomp_cal_en)
    else begin
      $error("rcomp_cal_en high while rcomp_cal_done is set");
      assert_fail_cnt++;
    end

  scan_code_zero: assert property (@(posedge sys_div_clk) disable iff (!rst_n)
    scan_mode |-> (rcomp_cal_code == '0))
    else begin
      $error("rcomp_cal_code not zero under scan_mode");
      assert_fail_cnt++;
    end

  // Two flop delay from request to acknowledge
  ack_after_load: assert property (@(posedge sys_div_clk) disable iff (!rst_n)
    $rose(clk_div_ld_ack) |-> $past(clk_div_ld, 2))
    else begin
      $error("clk_div_ld_ack rose without a load request");
      assert_fail_cnt++;
    end

  // Return from STOP rearms the machine and clears done on the next edge
  done_clear_on_start: assert property (@(posedge rcomp_clk) disable iff (!rst_n)
    (fsm_state == rcomp_pkg::START && $past(fsm_state) == rcomp_pkg::STOP)
      |=> (rcomp_cal_ovrd_sel || !rcomp_cal_done))
    else begin
      $error("rcomp_cal_done still high after a new start");
      assert_fail_cnt++;
    end

endmodule

bind rcomp_cal_top rcomp_cal_chk u_rcomp_cal_chk (
  .sys_div_clk        (sys_div_clk),
  .rcomp_clk          (rcomp_clk),
  .rst_n              (rst_n),
  .scan_mode          (scan_mode),
  .clk_div_ld         (clk_div_ld),
  .clk_div_ld_ack     (clk_div_ld_ack),
  .rcomp_cal_ovrd_sel (rcomp_cal_ovrd_sel),
  .rcomp_cal_en       (rcomp_cal_en),
  .rcomp_cal_done     (rcomp_cal_done),
  .rcomp_cal_code     (rcomp_cal_code),
  .fsm_state          (u_cal_fsm.rcomp_curst)
);

// ==== rcomp_cal_top.sv ====
// Rcomp calibration top level
// Divider, input synchronizers and calibration FSM on the divided clock

`timescale 1ns/1ns

module rcomp_cal_top #(
  parameter int RCOMP_WIDTH = rcomp_pkg::RCOMP_WIDTH_DEF
) (
  input  logic                   sys_div_clk,
  input  logic                   rst_n,
  input  logic                   scan_mode,
  input  logic                   clk_div_ld,
  input  clk_div_pkg::div_sel_t  clk_div_sel,
  input  logic                   pad_data,            // From pad comparator
  input  logic                   start_cal,
  input  logic                   gen1mode_en,
  input  logic                   rcomp_cal_ovrd_sel,
  input  logic                   rcomp_cal_done_ovrd,
  input  rcomp_pkg::rcomp_code_t rcomp_cal_code_ovrd,
  output logic                   rcomp_cal_en,
  output logic                   rcomp_cal_done,
  output rcomp_pkg::rcomp_code_t rcomp_cal_code,
  output logic                   clk_div_ld_ack
);

  logic rcomp_clk;   // Divided calibration clock
  logic pad_sync;
  logic start_sync;

  aib_clk_div_rcomp u_clk_div (
    .rst_n          (rst_n),
    .sys_div_clk    (sys_div_clk),
    .scan_mode      (scan_mode),
    .clk_div_ld     (clk_div_ld),
    .clk_div_sel    (clk_div_sel),
    .rcomp_clk      (rcomp_clk),
    .clk_div_ld_ack (clk_div_ld_ack)
  );

  rcomp_in_sync u_in_sync (
    .rcomp_clk  (rcomp_clk),
    .rst_n      (rst_n),
    .pad_data   (pad_data),
    .start_cal  (start_cal),
    .pad_sync   (pad_sync),
    .start_sync (start_sync)
  );

  rcomp_calibration_fsm #(
    .RCOMP_WIDTH (RCOMP_WIDTH)
  ) u_cal_fsm (
    .rcomp_clk           (rcomp_clk),
    .rst_n               (rst_n),
    .start_sync          (start_sync),
    .pad_sync            (pad_sync),
    .gen1mode_en         (gen1mode_en),
    .scan_mode           (scan_mode),
    .rcomp_cal_ovrd_sel  (rcomp_cal_ovrd_sel),
    .rcomp_cal_done_ovrd (rcomp_cal_done_ovrd),
    .rcomp_cal_code_ovrd (rcomp_cal_code_ovrd),
    .rcomp_cal_en        (rcomp_cal_en),
    .rcomp_cal_done      (rcomp_cal_done),
    .rcomp_cal_code      (rcomp_cal_code)
  );

endmodule

// ==== rcomp_calibration_fsm.sv ====
// Rcomp calibration state machine
// Counts rcomp_clk cycles until the comparator flips and forms the Gen1/Gen2 code

`timescale 1ns/1ns

module rcomp_calibration_fsm #(
  parameter int RCOMP_WIDTH = 7
) (
  input  logic                   rcomp_clk,
  input  logic                   rst_n,
  input  logic                   start_sync,
  input  logic                   pad_sync,
  input  logic                   gen1mode_en,
  input  logic                   scan_mode,
  input  logic                   rcomp_cal_ovrd_sel,
  input  logic                   rcomp_cal_done_ovrd,
  input  rcomp_pkg::rcomp_code_t rcomp_cal_code_ovrd,
  output logic                   rcomp_cal_en,
  output logic                   rcomp_cal_done,
  output rcomp_pkg::rcomp_code_t rcomp_cal_code     // 6 bits used in Gen1, 7 in Gen2
);

  // Full-scale limits in counter width
  localparam logic [RCOMP_WIDTH-1:0] GEN1_FS = RCOMP_WIDTH'(rcomp_pkg::GEN1_MAX);
  localparam logic [RCOMP_WIDTH-1:0] GEN2_FS = RCOMP_WIDTH'(rcomp_pkg::GEN2_MAX);

  rcomp_pkg::rcomp_state_e rcomp_curst, rcomp_nxst;
  logic [RCOMP_WIDTH-1:0]  code_cnt;      // Cycle counter, result in STOP
  logic [RCOMP_WIDTH-1:0]  edge_val;      // Count captured before the edge
  logic [1:0]              comp_data;     // Last two pad samples
  logic                    pad_edge;
  logic                    max_value;
  logic                    cal_done_int;
  logic [RCOMP_WIDTH-1:0]  code_int;

  assign pad_edge  = (comp_data[0] != comp_data[1]);
  assign max_value = gen1mode_en ? (code_cnt == GEN1_FS) : (code_cnt == GEN2_FS);

  // ==================
  // State register
  // ==================
  always_ff @(posedge rcomp_clk or negedge rst_n) begin
    if (!rst_n) begin
      rcomp_curst <= rcomp_pkg::START;
    end else begin
      rcomp_curst <= rcomp_nxst;
    end
  end

  always_comb begin
    rcomp_nxst = rcomp_curst;
    case (rcomp_curst)
      rcomp_pkg::START: begin
        if (start_sync) rcomp_nxst = rcomp_pkg::COUNT;
      end
      rcomp_pkg::COUNT: begin
        if (pad_edge || max_value) rcomp_nxst = rcomp_pkg::STOP;
      end
      rcomp_pkg::STOP: begin
        if (!start_sync) rcomp_nxst = rcomp_pkg::START;  // Rearm
      end
      default: rcomp_nxst = rcomp_pkg::START;
    endcase
  end

  // ==================
  // Count datapath
  // ==================
  always_ff @(posedge rcomp_clk or negedge rst_n) begin
    if (!rst_n) begin
      code_cnt     <= '0;
      edge_val     <= '0;
      comp_data    <= 2'b00;
      cal_done_int <= 1'b0;
      rcomp_cal_en <= 1'b0;
    end else begin
      case (rcomp_curst)
        rcomp_pkg::START: begin
          code_cnt     <= '0;
          comp_data    <= 2'b00;
          cal_done_int <= 1'b0;  // New run clears the old result flag
          rcomp_cal_en <= 1'b1;
        end
        rcomp_pkg::COUNT: begin
          comp_data    <= {comp_data[0], pad_sync};
          rcomp_cal_en <= 1'b1;
          if (pad_edge) begin
            edge_val <= code_cnt - RCOMP_WIDTH'(1);  // Count before the edge
            code_cnt <= '0;
          end else begin
            code_cnt <= code_cnt + RCOMP_WIDTH'(1);
          end
        end
        rcomp_pkg::STOP: begin
          code_cnt     <= edge_val;  // Full scale keeps the last capture
          cal_done_int <= 1'b1;
          rcomp_cal_en <= 1'b0;
        end
        default: begin
          comp_data    <= 2'b00;
          rcomp_cal_en <= 1'b1;
        end
      endcase
    end
  end

  // ==================
  // Output muxing
  // ==================
  // Gen2 pads expect the inverted count
  assign code_int = gen1mode_en ? code_cnt : ~code_cnt;

  // Scan wins over the register override
  always_comb begin
    if (scan_mode) begin
      rcomp_cal_code = '0;
    end else if (rcomp_cal_ovrd_sel) begin
      rcomp_cal_code = rcomp_cal_code_ovrd;
    end else begin
      rcomp_cal_code = rcomp_pkg::rcomp_code_t'(code_int);
    end
  end

  assign rcomp_cal_done = rcomp_cal_ovrd_sel ? rcomp_cal_done_ovrd : cal_done_int;

endmodule

// ==== rcomp_in_sync.sv ====
// Input synchronizers for the rcomp calibration
// Brings the pad comparator output and the start request into rcomp_clk

`timescale 1ns/1ns

module rcomp_in_sync (
  input  logic rcomp_clk,
  input  logic rst_n,
  input  logic pad_data,    // Asynchronous comparator output
  input  logic start_cal,   // Start request from register space
  output logic pad_sync,
  output logic start_sync
);

  // Bit 0 is the pad, bit 1 the start request
  logic [1:0] sync_meta;  // First stage, may go metastable
  logic [1:0] sync_q;     // Second stage, safe to use

  always_ff @(posedge rcomp_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_meta <= 2'b00;
      sync_q    <= 2'b00;
    end else begin
      sync_meta <= {start_cal, pad_data};
      sync_q    <= sync_meta;
    end
  end

  assign pad_sync   = sync_q[0];
  assign start_sync = sync_q[1];

endmodule

// ==== aib_clk_div_rcomp.sv ====
// Programmable clock divider for the rcomp calibration clock
// One-hot ratio 1..32, load with acknowledge, glitch-free switch, scan bypass

`timescale 1ns/1ns

module aib_clk_div_rcomp (
  input  logic                  rst_n,
  input  logic                  sys_div_clk,
  input  logic                  scan_mode,
  input  logic                  clk_div_ld,      // Level load request
  input  clk_div_pkg::div_sel_t clk_div_sel,     // One-hot ratio select
  output logic                  rcomp_clk,
  output logic                  clk_div_ld_ack
);

  logic [clk_div_pkg::DIV_CNT_W-1:0] div_cnt;  // Free running divide counter
  clk_div_pkg::div_sel_t             pend_sel;   // Last valid ratio from a load
  clk_div_pkg::div_sel_t             div_ratio;  // Ratio driving the output mux
  logic                              sel_onehot;
  logic                              cnt_zero;
  logic                              div_clk;
  logic                              ld_d1;

  // ==================
  // Load request
  // ==================
  // Exactly one bit set: nonzero and clearing the lowest set bit leaves zero
  assign sel_onehot = (clk_div_sel != '0) &&
                      ((clk_div_sel & (clk_div_sel - clk_div_pkg::div_sel_t'(1))) == '0);

  always_ff @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_sel <= clk_div_pkg::DIV_SEL_RESET;
    end else if (clk_div_ld && sel_onehot) begin
      pend_sel <= clk_div_sel;  // Invalid selects are dropped
    end
  end

  // Acknowledge is the request delayed by two clocks
  always_ff @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      ld_d1          <= 1'b0;
      clk_div_ld_ack <= 1'b0;
    end else begin
      ld_d1          <= clk_div_ld;
      clk_div_ld_ack <= ld_d1;
    end
  end

  // ==================
  // Divide counter
  // ==================
  always_ff @(posedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;  // Wraps every 32 clocks
    end
  end

  assign cnt_zero = (div_cnt == '0);

  // Ratio switches on the falling edge right after a wrap.
  // Every counter bit and the input clock are low there, so the mux output
  // does not change level at the switch point.
  always_ff @(negedge sys_div_clk or negedge rst_n) begin
    if (!rst_n) begin
      div_ratio <= clk_div_pkg::DIV_SEL_RESET;
    end else if (cnt_zero) begin
      div_ratio <= pend_sel;
    end
  end

  // ==================
  // Output clock mux
  // ==================
  always_comb begin
    case (div_ratio)
      clk_div_pkg::DIV_SEL_2:  div_clk = div_cnt[0];
      clk_div_pkg::DIV_SEL_4:  div_clk = div_cnt[1];
      clk_div_pkg::DIV_SEL_8:  div_clk = div_cnt[2];
      clk_div_pkg::DIV_SEL_16: div_clk = div_cnt[3];
      clk_div_pkg::DIV_SEL_32: div_clk = div_cnt[4];
      default:                 div_clk = sys_div_clk;  // Divide by 1
    endcase
  end

  // Scan runs the calibration logic on the input clock
  assign rcomp_clk = scan_mode ? sys_div_clk : div_clk;

endmodule

// ==== rcomp_pkg.sv ====
// Rcomp calibration package
// Code type, FSM state encoding and Gen1/Gen2 full-scale counts

package rcomp_pkg;

  // ==================
  // Code width and type
  // ==================
  localparam int RCOMP_WIDTH_DEF = 7;  // Gen2 code width, Gen1 uses the low 6 bits

  typedef logic [RCOMP_WIDTH_DEF-1:0] rcomp_code_t;

  // ==================
  // Full-scale counts
  // ==================
  // Counting ends here when the comparator never trips
  localparam int GEN1_MAX = 63;
  localparam int GEN2_MAX = 127;

  // ==================
  // FSM states
  // ==================
  typedef enum logic [1:0] {
    START = 2'b00,  // Wait for start request
    COUNT = 2'b01,  // Count until comparator edge
    STOP  = 2'b10   // Hold result until start drops
  } rcomp_state_e;

endpackage

// ==== clk_div_pkg.sv ====
// Clock divider package
// One-hot ratio select type and reset ratio for the rcomp clock

package clk_div_pkg;

  // Bit i selects divide by 2**i, so 6 bits cover 1 to 32
  localparam int DIV_SEL_W = 6;

  typedef logic [DIV_SEL_W-1:0] div_sel_t;

  // Counter needs one bit less than the select
  localparam int DIV_CNT_W = DIV_SEL_W - 1;

  // Divide by 1 after reset
  localparam div_sel_t DIV_SEL_RESET = 6'b000001;

  // Select values for the divider mux
  localparam div_sel_t DIV_SEL_2  = 6'b000010;
  localparam div_sel_t DIV_SEL_4  = 6'b000100;
  localparam div_sel_t DIV_SEL_8  = 6'b001000;
  localparam div_sel_t DIV_SEL_16 = 6'b010000;
  localparam div_sel_t DIV_SEL_32 = 6'b100000;

endpackage
